//--- hw/cache_pkg.sv
// Shared cache package
// Geometry, address fields, request and mode encodings
package cache_pkg;

  // --------------------
  // Geometry
  localparam int addr_w   = 32;
  localparam int data_w   = 32;
  localparam int num_sets = 8;
  localparam int idx_w    = 3;
  localparam int tag_w    = 27;
  localparam int cnt_w    = 10;
  localparam int max_ways = 3;

  // Byte offset of a word, below the index
  localparam int off_w = 2;

  // --------------------
  // Request and mode types
  typedef enum logic {
    req_read  = 1'b0,
    req_write = 1'b1
  } req_type_t;

  // Shared pool assignment, code 3 falls back to the split mapping
  typedef enum logic [1:0] {
    mode_split = 2'd0,
    mode_all_a = 2'd1,
    mode_all_b = 2'd2
  } mode_t;

  // --------------------
  // Address fields
  function automatic logic [idx_w-1:0] addr_idx(input logic [addr_w-1:0] addr);
    return addr[off_w +: idx_w];
  endfunction

  function automatic logic [tag_w-1:0] addr_tag(input logic [addr_w-1:0] addr);
    return addr[addr_w-1 -: tag_w];
  endfunction

endpackage

//--- hw/bank_if.sv
`timescale 1ns/1ps
// Cache way access
// One lookup or refill from a controller slot to a way
interface bank_if;
  import cache_pkg::*;

  // Request side
  logic              en;
  logic              write;
  logic [idx_w-1:0]  idx;
  logic [tag_w-1:0]  tag;
  logic [data_w-1:0] wr_data;

  // Result of a lookup, valid one cycle later
  logic [data_w-1:0] rd_data;
  logic              hit;

  modport user (
    output en,
    output write,
    output idx,
    output tag,
    output wr_data,
    input  rd_data,
    input  hit
  );

  modport bank (
    input  en,
    input  write,
    input  idx,
    input  tag,
    input  wr_data,
    output rd_data,
    output hit
  );

endinterface

//--- hw/cache_bank.sv
`timescale 1ns/1ps
// Cache way
// Tag, valid and data arrays with a registered tag compare
module cache_bank (
  input logic  clk,
  input logic  reset,
  input logic  flush,
  bank_if.bank bank
);
  import cache_pkg::*;

  logic [tag_w-1:0]    tag_array  [num_sets];
  logic [data_w-1:0]   data_array [num_sets];
  logic [num_sets-1:0] valid;

  // Lookup result registers
  logic              rd_valid;
  logic [tag_w-1:0]  rd_tag;
  logic [tag_w-1:0]  lookup_tag;
  logic [data_w-1:0] rd_word;

  logic do_lookup;
  logic do_write;

  assign do_lookup = bank.en && !bank.write;
  assign do_write  = bank.en && bank.write;

  // --------------------
  // Valid bits
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      valid <= '0;
    end else if (do_write) begin
      valid[bank.idx] <= 1'b1;
    end
  end

  // Tag and data arrays
  always_ff @(posedge clk) begin
    if (do_write) begin
      tag_array[bank.idx]  <= bank.tag;
      data_array[bank.idx] <= bank.wr_data;
    end
  end

  // --------------------
  // Lookup, compared one cycle later
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else if (do_lookup) begin
      rd_valid <= valid[bank.idx];
    end
  end

  always_ff @(posedge clk) begin
    if (do_lookup) begin
      rd_tag     <= tag_array[bank.idx];
      lookup_tag <= bank.tag;
      rd_word    <= data_array[bank.idx];
    end
  end

  assign bank.hit     = rd_valid && (rd_tag == lookup_tag);
  assign bank.rd_data = rd_word;

endmodule

//--- hw/shared_way_xbar.sv
`timescale 1ns/1ps
// Shared way crossbar
// Mode register, flush pulse and routing of ways 2 and 3 to the processors
module shared_way_xbar (
  input  logic             clk,
  input  logic             reset,
  input  cache_pkg::mode_t way_mode,
  input  logic             idle_a,
  input  logic             idle_b,
  bank_if.bank             a_slot1,
  bank_if.bank             a_slot2,
  bank_if.bank             b_slot1,
  bank_if.bank             b_slot2,
  bank_if.user             bank2,
  bank_if.user             bank3,
  output logic             flush,
  output logic [1:0]       ways_a,
  output logic [1:0]       ways_b
);
  import cache_pkg::*;

  mode_t mode_in;
  mode_t mode_r;
  logic  is_all_a;
  logic  is_all_b;

  // Unlisted code behaves as split
  always_comb begin
    case (way_mode)
      mode_all_a: mode_in = mode_all_a;
      mode_all_b: mode_in = mode_all_b;
      default:    mode_in = mode_split;
    endcase
  end

  // --------------------
  // Mode register, switched only while both sides are idle
  assign flush = idle_a && idle_b && (mode_in != mode_r);

  always_ff @(posedge clk) begin
    if (reset) begin
      mode_r <= mode_split;
    end else if (flush) begin
      mode_r <= mode_in;
    end
  end

  assign is_all_a = (mode_r == mode_all_a);
  assign is_all_b = (mode_r == mode_all_b);

  assign ways_a = is_all_a ? 2'd3 : (is_all_b ? 2'd1 : 2'd2);
  assign ways_b = is_all_b ? 2'd3 : (is_all_a ? 2'd1 : 2'd2);

  // --------------------
  // Bank 2 belongs to a unless all ways go to b
  assign bank2.en      = is_all_b ? b_slot1.en      : a_slot1.en;
  assign bank2.write   = is_all_b ? b_slot1.write   : a_slot1.write;
  assign bank2.idx     = is_all_b ? b_slot1.idx     : a_slot1.idx;
  assign bank2.tag     = is_all_b ? b_slot1.tag     : a_slot1.tag;
  assign bank2.wr_data = is_all_b ? b_slot1.wr_data : a_slot1.wr_data;

  // Bank 3 is b's second way, or the last way of the owning side
  assign bank3.en      = is_all_a ? a_slot2.en :
                         (is_all_b ? b_slot2.en : b_slot1.en);
  assign bank3.write   = is_all_a ? a_slot2.write :
                         (is_all_b ? b_slot2.write : b_slot1.write);
  assign bank3.idx     = is_all_a ? a_slot2.idx :
                         (is_all_b ? b_slot2.idx : b_slot1.idx);
  assign bank3.tag     = is_all_a ? a_slot2.tag :
                         (is_all_b ? b_slot2.tag : b_slot1.tag);
  assign bank3.wr_data = is_all_a ? a_slot2.wr_data :
                         (is_all_b ? b_slot2.wr_data : b_slot1.wr_data);

  // Results back to the slots, unassigned slots read as a miss
  assign a_slot1.hit     = !is_all_b && bank2.hit;
  assign a_slot1.rd_data = is_all_b ? '0 : bank2.rd_data;
  assign a_slot2.hit     = is_all_a && bank3.hit;
  assign a_slot2.rd_data = is_all_a ? bank3.rd_data : '0;
  assign b_slot1.hit     = is_all_b ? bank2.hit : (!is_all_a && bank3.hit);
  assign b_slot1.rd_data = is_all_b ? bank2.rd_data : (is_all_a ? '0 : bank3.rd_data);
  assign b_slot2.hit     = is_all_b && bank3.hit;
  assign b_slot2.rd_data = is_all_b ? bank3.rd_data : '0;

endmodule

//--- hw/cache_port_ctrl.sv
`timescale 1ns/1ps
// Per-processor cache controller
// Hit detection, read refill, write-through, victim pointers and counters
module cache_port_ctrl (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         flush,
  input  logic [1:0]                   ways,
  input  logic                         req_val,
  output logic                         req_rdy,
  input  cache_pkg::req_type_t         req_type,
  input  logic [cache_pkg::addr_w-1:0] req_addr,
  input  logic [cache_pkg::data_w-1:0] req_data,
  output logic                         resp_val,
  input  logic                         resp_rdy,
  output logic [cache_pkg::data_w-1:0] resp_data,
  output logic                         mem_req_val,
  input  logic                         mem_req_rdy,
  output cache_pkg::req_type_t         mem_req_type,
  output logic [cache_pkg::addr_w-1:0] mem_req_addr,
  output logic [cache_pkg::data_w-1:0] mem_req_data,
  input  logic                         mem_resp_val,
  output logic                         mem_resp_rdy,
  input  logic [cache_pkg::data_w-1:0] mem_resp_data,
  output logic                         idle,
  output logic [cache_pkg::cnt_w-1:0]  req_cnt,
  output logic [cache_pkg::cnt_w-1:0]  miss_cnt,
  bank_if.user                         slot0,
  bank_if.user                         slot1,
  bank_if.user                         slot2
);
  import cache_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_mem_request,
    st_mem_wait,
    st_respond
  } state_t;

  state_t state;
  state_t state_next;

  // Registered request
  req_type_t         req_type_r;
  logic [addr_w-1:0] req_addr_r;
  logic [data_w-1:0] req_data_r;
  logic [data_w-1:0] resp_data_r;

  // Round-robin victim per set
  logic [num_sets-1:0][1:0] victim;
  logic [1:0]               victim_way;
  logic [1:0]               victim_next;

  logic                accept;
  logic                is_read;
  logic                refill;
  logic [addr_w-1:0]   cur_addr;
  logic [idx_w-1:0]    cur_idx;
  logic [max_ways-1:0] slot_hit;
  logic [max_ways-1:0] slot_en;
  logic [max_ways-1:0] slot_write;
  logic [data_w-1:0]   slot_data [max_ways];
  logic [data_w-1:0]   wr_word;
  logic                any_hit;
  logic [1:0]          hit_way;
  logic [data_w-1:0]   hit_data;

  // --------------------
  // Handshakes
  assign idle         = (state == st_idle);
  assign req_rdy      = idle && !flush;
  assign accept       = req_val && req_rdy;
  assign resp_val     = (state == st_respond);
  assign resp_data    = resp_data_r;
  assign mem_req_val  = (state == st_mem_request);
  assign mem_req_type = req_type_r;
  assign mem_req_addr = req_addr_r;
  assign mem_req_data = req_data_r;
  assign mem_resp_rdy = (state == st_mem_wait);

  assign is_read = (req_type_r == req_read);
  assign refill  = (state == st_mem_wait) && mem_resp_val && is_read;

  // Lookup uses the incoming address, later steps the registered one
  assign cur_addr = idle ? req_addr : req_addr_r;
  assign cur_idx  = addr_idx(cur_addr);

  // --------------------
  // Slot results, first hit wins
  assign slot_hit     = {slot2.hit, slot1.hit, slot0.hit};
  assign slot_data[0] = slot0.rd_data;
  assign slot_data[1] = slot1.rd_data;
  assign slot_data[2] = slot2.rd_data;
  assign any_hit      = |slot_hit;

  always_comb begin
    hit_way  = 2'd0;
    hit_data = slot_data[0];
    for (int i = max_ways - 1; i >= 0; i--) begin
      if (slot_hit[i]) begin
        hit_way  = 2'(i);
        hit_data = slot_data[i];
      end
    end
  end

  assign victim_way  = victim[cur_idx];
  assign victim_next = (victim_way + 2'd1 >= ways) ? 2'd0 : victim_way + 2'd1;

  // Slot requests
  always_comb begin
    slot_en    = '0;
    slot_write = '0;
    case (state)
      st_idle: slot_en = {max_ways{accept}};
      st_lookup: begin
        if (!is_read && any_hit) begin
          slot_en[hit_way]    = 1'b1;
          slot_write[hit_way] = 1'b1;
        end
      end
      st_mem_wait: begin
        if (refill) begin
          slot_en[victim_way]    = 1'b1;
          slot_write[victim_way] = 1'b1;
        end
      end
      default: begin
      end
    endcase
  end

  // Refill takes the memory word, a write hit the request word
  assign wr_word = (state == st_mem_wait) ? mem_resp_data : req_data_r;

  assign slot0.en      = slot_en[0];
  assign slot0.write   = slot_write[0];
  assign slot0.idx     = cur_idx;
  assign slot0.tag     = addr_tag(cur_addr);
  assign slot0.wr_data = wr_word;
  assign slot1.en      = slot_en[1];
  assign slot1.write   = slot_write[1];
  assign slot1.idx     = cur_idx;
  assign slot1.tag     = addr_tag(cur_addr);
  assign slot1.wr_data = wr_word;
  assign slot2.en      = slot_en[2];
  assign slot2.write   = slot_write[2];
  assign slot2.idx     = cur_idx;
  assign slot2.tag     = addr_tag(cur_addr);
  assign slot2.wr_data = wr_word;

  // --------------------
  // FSM
  always_comb begin
    state_next = state;
    case (state)
      st_idle:        if (accept) state_next = st_lookup;
      st_lookup:      state_next = (is_read && any_hit) ? st_respond : st_mem_request;
      st_mem_request: if (mem_req_rdy) state_next = st_mem_wait;
      st_mem_wait:    if (mem_resp_val) state_next = st_respond;
      st_respond:     if (resp_rdy) state_next = st_idle;
      default:        state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_type_r <= req_type;
      req_addr_r <= req_addr;
      req_data_r <= req_data;
    end
    if (state == st_lookup && is_read && any_hit) begin
      resp_data_r <= hit_data;
    end else if (state == st_mem_wait && mem_resp_val) begin
      resp_data_r <= mem_resp_data;
    end
  end

  // Counters wrap
  always_ff @(posedge clk) begin
    if (reset) begin
      req_cnt  <= '0;
      miss_cnt <= '0;
    end else begin
      if (accept) req_cnt <= req_cnt + cnt_w'(1);
      if (state == st_lookup && !any_hit) miss_cnt <= miss_cnt + cnt_w'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      victim <= '0;
    end else if (refill) begin
      victim[cur_idx] <= victim_next;
    end
  end

endmodule

//--- hw/shared_cache.sv
`timescale 1ns/1ps
// Shared cache top
// Two private ways, two pooled ways and one controller per processor
module shared_cache (
  input  logic                         clk,
  input  logic                         reset,
  input  cache_pkg::mode_t             way_mode,
  // Processor a
  input  logic                         req_val_a,
  output logic                         req_rdy_a,
  input  cache_pkg::req_type_t         req_type_a,
  input  logic [cache_pkg::addr_w-1:0] req_addr_a,
  input  logic [cache_pkg::data_w-1:0] req_data_a,
  output logic                         resp_val_a,
  input  logic                         resp_rdy_a,
  output logic [cache_pkg::data_w-1:0] resp_data_a,
  output logic                         mem_req_val_a,
  input  logic                         mem_req_rdy_a,
  output cache_pkg::req_type_t         mem_req_type_a,
  output logic [cache_pkg::addr_w-1:0] mem_req_addr_a,
  output logic [cache_pkg::data_w-1:0] mem_req_data_a,
  input  logic                         mem_resp_val_a,
  output logic                         mem_resp_rdy_a,
  input  logic [cache_pkg::data_w-1:0] mem_resp_data_a,
  output logic [cache_pkg::cnt_w-1:0]  req_cnt_a,
  output logic [cache_pkg::cnt_w-1:0]  miss_cnt_a,
  // Processor b
  input  logic                         req_val_b,
  output logic                         req_rdy_b,
  input  cache_pkg::req_type_t         req_type_b,
  input  logic [cache_pkg::addr_w-1:0] req_addr_b,
  input  logic [cache_pkg::data_w-1:0] req_data_b,
  output logic                         resp_val_b,
  input  logic                         resp_rdy_b,
  output logic [cache_pkg::data_w-1:0] resp_data_b,
  output logic                         mem_req_val_b,
  input  logic                         mem_req_rdy_b,
  output cache_pkg::req_type_t         mem_req_type_b,
  output logic [cache_pkg::addr_w-1:0] mem_req_addr_b,
  output logic [cache_pkg::data_w-1:0] mem_req_data_b,
  input  logic                         mem_resp_val_b,
  output logic                         mem_resp_rdy_b,
  input  logic [cache_pkg::data_w-1:0] mem_resp_data_b,
  output logic [cache_pkg::cnt_w-1:0]  req_cnt_b,
  output logic [cache_pkg::cnt_w-1:0]  miss_cnt_b
);

  logic       flush;
  logic       idle_a;
  logic       idle_b;
  logic [1:0] ways_a;
  logic [1:0] ways_b;

  // Controller slots and shared bank ports
  bank_if a_slot0 ();
  bank_if a_slot1 ();
  bank_if a_slot2 ();
  bank_if b_slot0 ();
  bank_if b_slot1 ();
  bank_if b_slot2 ();
  bank_if bank2_port ();
  bank_if bank3_port ();

  // --------------------
  // Ways, private ones never flush
  cache_bank bank0_inst (.clk(clk), .reset(reset), .flush(1'b0), .bank(a_slot0));
  cache_bank bank1_inst (.clk(clk), .reset(reset), .flush(1'b0), .bank(b_slot0));
  cache_bank bank2_inst (.clk(clk), .reset(reset), .flush(flush), .bank(bank2_port));
  cache_bank bank3_inst (.clk(clk), .reset(reset), .flush(flush), .bank(bank3_port));

  shared_way_xbar xbar_inst (
    .clk(clk), .reset(reset), .way_mode(way_mode),
    .idle_a(idle_a), .idle_b(idle_b),
    .a_slot1(a_slot1), .a_slot2(a_slot2), .b_slot1(b_slot1), .b_slot2(b_slot2),
    .bank2(bank2_port), .bank3(bank3_port),
    .flush(flush), .ways_a(ways_a), .ways_b(ways_b)
  );

  // --------------------
  // Controllers
  cache_port_ctrl ctrl_a_inst (
    .clk(clk), .reset(reset), .flush(flush), .ways(ways_a),
    .req_val(req_val_a), .req_rdy(req_rdy_a), .req_type(req_type_a),
    .req_addr(req_addr_a), .req_data(req_data_a),
    .resp_val(resp_val_a), .resp_rdy(resp_rdy_a), .resp_data(resp_data_a),
    .mem_req_val(mem_req_val_a), .mem_req_rdy(mem_req_rdy_a),
    .mem_req_type(mem_req_type_a), .mem_req_addr(mem_req_addr_a),
    .mem_req_data(mem_req_data_a),
    .mem_resp_val(mem_resp_val_a), .mem_resp_rdy(mem_resp_rdy_a),
    .mem_resp_data(mem_resp_data_a),
    .idle(idle_a), .req_cnt(req_cnt_a), .miss_cnt(miss_cnt_a),
    .slot0(a_slot0), .slot1(a_slot1), .slot2(a_slot2)
  );

  cache_port_ctrl ctrl_b_inst (
    .clk(clk), .reset(reset), .flush(flush), .ways(ways_b),
    .req_val(req_val_b), .req_rdy(req_rdy_b), .req_type(req_type_b),
    .req_addr(req_addr_b), .req_data(req_data_b),
    .resp_val(resp_val_b), .resp_rdy(resp_rdy_b), .resp_data(resp_data_b),
    .mem_req_val(mem_req_val_b), .mem_req_rdy(mem_req_rdy_b),
    .mem_req_type(mem_req_type_b), .mem_req_addr(mem_req_addr_b),
    .mem_req_data(mem_req_data_b),
    .mem_resp_val(mem_resp_val_b), .mem_resp_rdy(mem_resp_rdy_b),
    .mem_resp_data(mem_resp_data_b),
    .idle(idle_b), .req_cnt(req_cnt_b), .miss_cnt(miss_cnt_b),
    .slot0(b_slot0), .slot1(b_slot1), .slot2(b_slot2)
  );

endmodule

//--- sim/shared_cache_tb.sv
`timescale 1ns/1ps
// Shared cache testbench
// Random traffic on both processors through three pool modes, against memory and cache models
module shared_cache_tb;
  import cache_pkg::*;

  localparam int num_phases     = 3;
  localparam int reqs_per_phase = 300;
  localparam int cycles_per_req = 20;
  localparam int timeout_cycles = num_phases * reqs_per_phase * cycles_per_req + 2000;

  logic clk = 1'b0;
  logic reset;
  mode_t way_mode;

  // Index 0 is processor a, index 1 is processor b
  logic [1:0]             req_val;
  logic [1:0]             req_rdy;
  req_type_t              req_type [2];
  logic [1:0][31:0]       req_addr;
  logic [1:0][31:0]       req_data;
  logic [1:0]             resp_val;
  logic [1:0]             resp_rdy;
  logic [1:0][31:0]       resp_data;
  logic [1:0]             mem_req_val;
  logic [1:0]             mem_req_rdy;
  req_type_t              mem_req_type [2];
  logic [1:0][31:0]       mem_req_addr;
  logic [1:0][31:0]       mem_req_data;
  logic [1:0]             mem_resp_val;
  logic [1:0]             mem_resp_rdy;
  logic [1:0][31:0]       mem_resp_data;
  logic [1:0][cnt_w-1:0]  req_cnt;
  logic [1:0][cnt_w-1:0]  miss_cnt;

  // Memory model, 16 tags by 8 sets per processor
  logic [31:0] mem_word [2][128];
  logic [31:0] cur_addr [2];
  logic [31:0] cur_data [2];
  logic        pend_write [2];

  // Cache model
  logic [3:0]       m_tag    [2][3][8];
  logic             m_valid  [2][3][8];
  logic [1:0]       m_victim [2][8];
  int               m_ways   [2];
  logic [cnt_w-1:0] m_req    [2];
  logic [cnt_w-1:0] m_miss   [2];

  string       side [2] = '{"a", "b"};
  logic [31:0] lfsr = 32'd76580;
  int          errors = 0;
  int          cycle_cnt = 0;

  shared_cache shared_cache_inst (
    .clk(clk), .reset(reset), .way_mode(way_mode),
    .req_val_a(req_val[0]), .req_rdy_a(req_rdy[0]), .req_type_a(req_type[0]),
    .req_addr_a(req_addr[0]), .req_data_a(req_data[0]),
    .resp_val_a(resp_val[0]), .resp_rdy_a(resp_rdy[0]), .resp_data_a(resp_data[0]),
    .mem_req_val_a(mem_req_val[0]), .mem_req_rdy_a(mem_req_rdy[0]),
    .mem_req_type_a(mem_req_type[0]), .mem_req_addr_a(mem_req_addr[0]),
    .mem_req_data_a(mem_req_data[0]), .mem_resp_val_a(mem_resp_val[0]),
    .mem_resp_rdy_a(mem_resp_rdy[0]), .mem_resp_data_a(mem_resp_data[0]),
    .req_cnt_a(req_cnt[0]), .miss_cnt_a(miss_cnt[0]),
    .req_val_b(req_val[1]), .req_rdy_b(req_rdy[1]), .req_type_b(req_type[1]),
    .req_addr_b(req_addr[1]), .req_data_b(req_data[1]),
    .resp_val_b(resp_val[1]), .resp_rdy_b(resp_rdy[1]), .resp_data_b(resp_data[1]),
    .mem_req_val_b(mem_req_val[1]), .mem_req_rdy_b(mem_req_rdy[1]),
    .mem_req_type_b(mem_req_type[1]), .mem_req_addr_b(mem_req_addr[1]),
    .mem_req_data_b(mem_req_data[1]), .mem_resp_val_b(mem_resp_val[1]),
    .mem_resp_rdy_b(mem_resp_rdy[1]), .mem_resp_data_b(mem_resp_data[1]),
    .req_cnt_b(req_cnt[1]), .miss_cnt_b(miss_cnt[1])
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout: the requests did not finish within %0d cycles", timeout_cycles);
      $display("Something failed");
      $fatal(1, "timeout");
    end
  end

  // --------------------
  // Helpers
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  // Bit 31 splits the two processors, tag in bits 8 to 5, set in 4 to 2
  function automatic logic [31:0] make_addr(input int p, input logic [6:0] word_idx);
    return {1'(p), 22'd0, word_idx, 2'b00};
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr ^ {addr[15:0], addr[31:16]}) + 32'h3C5A_96E1;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      $display("Something failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // --------------------
  // Cache model
  task automatic model_access(input int p, input logic is_wr, input logic [3:0] t,
                              input logic [2:0] s);
    logic       hit;
    logic [1:0] v;
    hit = 1'b0;
    for (int w = 0; w < m_ways[p]; w++) begin
      if (m_valid[p][w][s] && m_tag[p][w][s] == t) hit = 1'b1;
    end
    m_req[p] = m_req[p] + 10'd1;
    if (!hit) begin
      m_miss[p] = m_miss[p] + 10'd1;
      // No allocate on a write miss
      if (!is_wr) begin
        v = m_victim[p][s];
        m_tag[p][v][s]   = t;
        m_valid[p][v][s] = 1'b1;
        m_victim[p][s]   = (32'(v) + 1 >= m_ways[p]) ? 2'd0 : v + 2'd1;
      end
    end
  endtask

  // Shared ways lose their lines and all pointers restart at way 0
  task automatic set_mode(input mode_t m, input int ways_a, input int ways_b);
    way_mode  = m;
    m_ways[0] = ways_a;
    m_ways[1] = ways_b;
    for (int p = 0; p < 2; p++) begin
      for (int s = 0; s < 8; s++) begin
        m_valid[p][1][s] = 1'b0;
        m_valid[p][2][s] = 1'b0;
        m_victim[p][s]   = 2'd0;
      end
    end
  endtask

  // --------------------
  // Memory model
  task automatic serve_memory(input int p);
    logic [31:0] addr;
    logic [31:0] word;
    logic        got;
    int          lat;
    forever begin
      @(negedge clk);
      if (mem_req_val[p] && mem_req_rdy[p]) begin
        addr = mem_req_addr[p];
        check_value({"memory address ", side[p]}, cur_addr[p], addr);
        if (mem_req_type[p] == req_write) begin
          check_value({"memory write pending ", side[p]}, 32'd1, 32'(pend_write[p]));
          check_value({"memory write data ", side[p]}, cur_data[p], mem_req_data[p]);
          mem_word[p][addr[8:2]] = mem_req_data[p];
          pend_write[p] = 1'b0;
          word = '0;
        end else begin
          word = mem_word[p][addr[8:2]];
        end
        lat = int'(rand_bits(3) % 6);
        @(posedge clk);
        #1;
        repeat (lat) begin
          @(posedge clk);
          #1;
        end
        mem_resp_val[p]  = 1'b1;
        mem_resp_data[p] = word;
        got = 1'b0;
        while (!got) begin
          @(negedge clk);
          got = mem_resp_rdy[p];
          @(posedge clk);
          #1;
        end
        mem_resp_val[p] = 1'b0;
      end
    end
  endtask

  // --------------------
  // Processor traffic
  task automatic run_requests(input int p, input int n);
    logic [3:0]  t;
    logic [2:0]  s;
    logic        is_wr;
    logic        accepted;
    logic        done;
    logic        held;
    logic [31:0] expected;
    logic [31:0] last_data;
    for (int k = 0; k < n; k++) begin
      t = 4'(rand_bits(4));
      s = 3'(rand_bits(3));
      is_wr = (rand_bits(2) == 0);
      cur_addr[p] = make_addr(p, {t, s});
      cur_data[p] = rand_bits(32);
      req_val[p]  = 1'b1;
      req_type[p] = is_wr ? req_write : req_read;
      req_addr[p] = cur_addr[p];
      req_data[p] = cur_data[p];
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        accepted = req_rdy[p];
        @(posedge clk);
        #1;
      end
      req_val[p] = 1'b0;
      expected = mem_word[p][{t, s}];
      pend_write[p] = is_wr;
      model_access(p, is_wr, t, s);

      // Response under a random ready
      done = 1'b0;
      held = 1'b0;
      last_data = '0;
      while (!done) begin
        resp_rdy[p] = rand_bits(1) != 0;
        @(negedge clk);
        if (held) begin
          check_value({"resp_val held ", side[p]}, 32'd1, 32'(resp_val[p]));
          check_value({"resp_data held ", side[p]}, last_data, resp_data[p]);
        end
        held = resp_val[p] && !resp_rdy[p];
        last_data = resp_data[p];
        done = resp_val[p] && resp_rdy[p];
        @(posedge clk);
        #1;
      end
      resp_rdy[p] = 1'b0;
      if (is_wr) begin
        check_value({"write reached memory ", side[p]}, 32'd0, 32'(pend_write[p]));
      end else begin
        check_value({"read data ", side[p]}, expected, last_data);
      end
      @(negedge clk);
      check_value({"single response ", side[p]}, 32'd0, 32'(resp_val[p]));
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_phase();
    fork
      run_requests(0, reqs_per_phase);
      run_requests(1, reqs_per_phase);
    join
    @(negedge clk);
    for (int p = 0; p < 2; p++) begin
      check_value({"req_cnt ", side[p]}, 32'(m_req[p]), 32'(req_cnt[p]));
      check_value({"miss_cnt ", side[p]}, 32'(m_miss[p]), 32'(miss_cnt[p]));
    end
    @(posedge clk);
    #1;
  endtask

  // --------------------
  // Main sequence
  initial begin
    reset         = 1'b1;
    way_mode      = mode_split;
    req_val       = '0;
    req_addr      = '0;
    req_data      = '0;
    resp_rdy      = '0;
    mem_req_rdy   = 2'b11;
    mem_resp_val  = '0;
    mem_resp_data = '0;
    for (int p = 0; p < 2; p++) begin
      req_type[p]   = req_read;
      pend_write[p] = 1'b0;
      cur_addr[p]   = '0;
      cur_data[p]   = '0;
      m_req[p]      = '0;
      m_miss[p]     = '0;
      for (int i = 0; i < 128; i++) mem_word[p][i] = fill_word(make_addr(p, 7'(i)));
      for (int s = 0; s < 8; s++) begin
        m_valid[p][0][s] = 1'b0;
        m_tag[p][0][s]   = '0;
        m_tag[p][1][s]   = '0;
        m_tag[p][2][s]   = '0;
      end
    end
    set_mode(mode_split, 2, 2);
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    fork
      serve_memory(0);
      serve_memory(1);
    join_none

    run_phase();
    set_mode(mode_all_a, 3, 1);
    run_phase();
    set_mode(mode_all_b, 1, 3);
    run_phase();

    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- shared_cache.f
hw/cache_pkg.sv
hw/bank_if.sv
hw/cache_bank.sv
hw/shared_way_xbar.sv
hw/cache_port_ctrl.sv
hw/shared_cache.sv
sim/shared_cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the shared cache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
  --top-module shared_cache_tb \
  -f shared_cache.f \
  -o shared_cache_sim

./obj_dir/shared_cache_sim | tee sim.log

if grep -q "Everything OK" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
